// File: arb_pkg.sv
`default_nettype none

package arb_pkg;

  // one scratchpad row is two memory words
  localparam int ROW_W = 64;

  // rows fetched by one scratchpad load
  localparam int SP_ROWS = 4;
  localparam int ROW_IDX_W = 2;

  // byte step between consecutive rows
  localparam int ROW_STRIDE = 8;

  // byte offset of the upper word inside a row
  localparam int HALF_OFFSET = 4;

  // arbiter FSM states
  typedef enum logic [2:0] {
    IDLE      = 3'b000,
    SP_LOAD1  = 3'b001,
    SP_LOAD2  = 3'b010,
    SP_STORE1 = 3'b011,
    SP_STORE2 = 3'b100,
    DCACHE    = 3'b101,
    ICACHE    = 3'b110
  } arb_state_e;

endpackage

`default_nettype wire

// File: files.f
mem_pkg.sv
arb_pkg.sv
main_ram.sv
memory_arbiter.sv
scratchpad_buffer.sv
mem_subsys_top.sv
mem_subsys_assertions.sv
tb_mem_subsys.sv

// File: main_ram.sv
`default_nettype none

module main_ram (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic [mem_pkg::WORD_W-1:0] ram_addr,
  input  logic [mem_pkg::WORD_W-1:0] ram_wdata,
  input  logic                       ram_ren,
  input  logic                       ram_wen,
  output logic [mem_pkg::WORD_W-1:0] ram_rdata,
  output mem_pkg::ram_state_e        ram_state
);
  import mem_pkg::*;

  logic [WORD_W-1:0] mem [RAM_DEPTH];
  logic [LAT_W-1:0]  lat_cnt;
  logic [RAM_AW-1:0] word_addr;
  logic              req;

  assign req = ram_ren | ram_wen;

  // byte address, word aligned
  assign word_addr = ram_addr[RAM_AW+1:2];

  // counter runs while a request is held and wraps after the access cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lat_cnt <= '0;
    end
    else if (req && (lat_cnt != LAT_W'(RAM_LATENCY))) begin
      lat_cnt <= lat_cnt + 1'b1;
    end
    else begin
      lat_cnt <= '0;
    end
  end

  always_comb begin
    if (!req) begin
      ram_state = FREE;
    end
    else if (lat_cnt == LAT_W'(RAM_LATENCY)) begin
      ram_state = ACCESS;
    end
    else begin
      ram_state = BUSY;
    end
  end

  // write lands at the end of the access cycle
  always_ff @(posedge CLK) begin
    if (ram_wen && (ram_state == ACCESS)) begin
      mem[word_addr] <= ram_wdata;
    end
  end

  // fetch on the last busy edge so the word is there during access
  always_ff @(posedge CLK) begin
    if (ram_ren && (lat_cnt == LAT_W'(RAM_LATENCY - 1))) begin
      ram_rdata <= mem[word_addr];
    end
  end

endmodule

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

  // data and address width of the shared bus
  localparam int WORD_W = 32;

  // main_ram size in words
  localparam int RAM_DEPTH = 1024;

  // word index bits taken from the byte address
  localparam int RAM_AW = $clog2(RAM_DEPTH);

  // busy cycles before each access cycle
  localparam int RAM_LATENCY = 2;

  // latency counter width, counts 0 .. RAM_LATENCY
  localparam int LAT_W = $clog2(RAM_LATENCY + 1);

  // status the RAM reports back to the arbiter
  typedef enum logic [1:0] {
    FREE   = 2'b00,
    BUSY   = 2'b01,
    ACCESS = 2'b10
  } ram_state_e;

endpackage

`default_nettype wire

// File: mem_subsys_assertions.sv
`default_nettype none

module mem_subsys_assertions (
  input logic                          CLK,
  input logic                          nRST,
  input logic                          d_ren,
  input logic                          d_wen,
  input logic                          d_wait,
  input logic                          i_ren,
  input logic                          i_wait,
  input logic                          sp_row_valid,
  input logic [arb_pkg::ROW_IDX_W-1:0] sp_row_idx,
  input logic                          sp_store_done,
  input logic [mem_pkg::WORD_W-1:0]    sp_store_addr,
  input logic                          ram_ren,
  input logic                          ram_wen,
  input logic [mem_pkg::WORD_W-1:0]    ram_addr,
  input arb_pkg::arb_state_e           state
);
  timeunit 1ns;
  timeprecision 1ps;
  import mem_pkg::*;
  import arb_pkg::*;

  int unsigned          fail_cnt = 0;
  logic [ROW_IDX_W-1:0] exp_idx;

  // row index the next pulse must carry
  // cleared while the arbiter idles
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exp_idx <= '0;
    end
    else if (sp_row_valid) begin
      exp_idx <= exp_idx + 1'b1;
    end
    else if (state == IDLE) begin
      exp_idx <= '0;
    end
  end

  ram_exclusive: assert property (@(posedge CLK) disable iff (!nRST) !(ram_ren && ram_wen))
    else begin
      $error("RAM read and write enables high in the same cycle");
      fail_cnt++;
    end

  d_grant: assert property (@(posedge CLK) disable iff (!nRST) !d_wait |-> (d_ren || d_wen))
    else begin
      $error("d_wait low without a data cache request");
      fail_cnt++;
    end

  i_grant: assert property (@(posedge CLK) disable iff (!nRST) !i_wait |-> i_ren)
    else begin
      $error("i_wait low without an instruction cache request");
      fail_cnt++;
    end

  row_single: assert property (@(posedge CLK) disable iff (!nRST)
                               sp_row_valid |=> !sp_row_valid)
    else begin
      $error("sp_row_valid held longer than one cycle");
      fail_cnt++;
    end

  row_order: assert property (@(posedge CLK) disable iff (!nRST)
                              sp_row_valid |-> (sp_row_idx == exp_idx))
    else begin
      $error("row index out of sequence");
      fail_cnt++;
    end

  // done pulse follows a busy cycle of the same upper word write
  store_upper: assert property (@(posedge CLK) disable iff (!nRST)
      sp_store_done |-> ram_wen && (ram_addr == sp_store_addr + WORD_W'(HALF_OFFSET))
                        && $past(ram_wen) && ($past(ram_addr) == ram_addr))
    else begin
      $error("store done without a write to the upper word address");
      fail_cnt++;
    end

endmodule

bind memory_arbiter mem_subsys_assertions u_checks (
  .CLK           (CLK),
  .nRST          (nRST),
  .d_ren         (d_ren),
  .d_wen         (d_wen),
  .d_wait        (d_wait),
  .i_ren         (i_ren),
  .i_wait        (i_wait),
  .sp_row_valid  (sp_row_valid),
  .sp_row_idx    (sp_row_idx),
  .sp_store_done (sp_store_done),
  .sp_store_addr (sp_store_addr),
  .ram_ren       (ram_ren),
  .ram_wen       (ram_wen),
  .ram_addr      (ram_addr),
  .state         (state)
);

`default_nettype wire

// File: mem_subsys_top.sv
`default_nettype none

module mem_subsys_top (
  input  logic                          CLK,
  input  logic                          nRST,
  // data cache port
  input  logic                          d_ren,
  input  logic                          d_wen,
  input  logic [mem_pkg::WORD_W-1:0]    d_addr,
  input  logic [mem_pkg::WORD_W-1:0]    d_wdata,
  output logic                          d_wait,
  output logic [mem_pkg::WORD_W-1:0]    d_rdata,
  // instruction cache port
  input  logic                          i_ren,
  input  logic [mem_pkg::WORD_W-1:0]    i_addr,
  output logic                          i_wait,
  output logic [mem_pkg::WORD_W-1:0]    i_rdata,
  // scratchpad port
  input  logic                          sp_load,
  input  logic [mem_pkg::WORD_W-1:0]    sp_load_addr,
  input  logic                          sp_store,
  input  logic [mem_pkg::WORD_W-1:0]    sp_store_addr,
  input  logic [arb_pkg::ROW_W-1:0]     sp_store_data,
  output logic                          sp_row_valid,
  output logic [arb_pkg::ROW_IDX_W-1:0] sp_row_idx,
  output logic [arb_pkg::ROW_W-1:0]     sp_row_data,
  output logic                          sp_store_done,
  // scratchpad buffer read back
  input  logic [arb_pkg::ROW_IDX_W-1:0] sp_rd_idx,
  output logic [arb_pkg::ROW_W-1:0]     sp_rd_row
);
  import mem_pkg::*;

  logic [WORD_W-1:0] ram_addr;
  logic [WORD_W-1:0] ram_wdata;
  logic [WORD_W-1:0] ram_rdata;
  logic              ram_ren;
  logic              ram_wen;
  ram_state_e        ram_state;

  memory_arbiter u_arbiter (
    .CLK           (CLK),
    .nRST          (nRST),
    .d_ren         (d_ren),
    .d_wen         (d_wen),
    .d_addr        (d_addr),
    .d_wdata       (d_wdata),
    .d_wait        (d_wait),
    .d_rdata       (d_rdata),
    .i_ren         (i_ren),
    .i_addr        (i_addr),
    .i_wait        (i_wait),
    .i_rdata       (i_rdata),
    .sp_load       (sp_load),
    .sp_load_addr  (sp_load_addr),
    .sp_store      (sp_store),
    .sp_store_addr (sp_store_addr),
    .sp_store_data (sp_store_data),
    .sp_row_valid  (sp_row_valid),
    .sp_row_idx    (sp_row_idx),
    .sp_row_data   (sp_row_data),
    .sp_store_done (sp_store_done),
    .ram_state     (ram_state),
    .ram_rdata     (ram_rdata),
    .ram_addr      (ram_addr),
    .ram_wdata     (ram_wdata),
    .ram_ren       (ram_ren),
    .ram_wen       (ram_wen)
  );

  main_ram u_ram (
    .CLK       (CLK),
    .nRST      (nRST),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_ren   (ram_ren),
    .ram_wen   (ram_wen),
    .ram_rdata (ram_rdata),
    .ram_state (ram_state)
  );

  // rows land here as the load streams them out
  scratchpad_buffer u_sp_buf (
    .CLK       (CLK),
    .nRST      (nRST),
    .row_valid (sp_row_valid),
    .row_idx   (sp_row_idx),
    .row_data  (sp_row_data),
    .rd_idx    (sp_rd_idx),
    .rd_row    (sp_rd_row)
  );

endmodule

`default_nettype wire

// File: memory_arbiter.sv
`default_nettype none

module memory_arbiter (
  input  logic                           CLK,
  input  logic                           nRST,
  // data cache port
  input  logic                           d_ren,
  input  logic                           d_wen,
  input  logic [mem_pkg::WORD_W-1:0]     d_addr,
  input  logic [mem_pkg::WORD_W-1:0]     d_wdata,
  output logic                           d_wait,
  output logic [mem_pkg::WORD_W-1:0]     d_rdata,
  // instruction cache port
  input  logic                           i_ren,
  input  logic [mem_pkg::WORD_W-1:0]     i_addr,
  output logic                           i_wait,
  output logic [mem_pkg::WORD_W-1:0]     i_rdata,
  // scratchpad port
  input  logic                           sp_load,
  input  logic [mem_pkg::WORD_W-1:0]     sp_load_addr,
  input  logic                           sp_store,
  input  logic [mem_pkg::WORD_W-1:0]     sp_store_addr,
  input  logic [arb_pkg::ROW_W-1:0]      sp_store_data,
  output logic                           sp_row_valid,
  output logic [arb_pkg::ROW_IDX_W-1:0]  sp_row_idx,
  output logic [arb_pkg::ROW_W-1:0]      sp_row_data,
  output logic                           sp_store_done,
  // main memory side
  input  mem_pkg::ram_state_e            ram_state,
  input  logic [mem_pkg::WORD_W-1:0]     ram_rdata,
  output logic [mem_pkg::WORD_W-1:0]     ram_addr,
  output logic [mem_pkg::WORD_W-1:0]     ram_wdata,
  output logic                           ram_ren,
  output logic                           ram_wen
);
  import mem_pkg::*;
  import arb_pkg::*;

  arb_state_e           state;
  arb_state_e           next_state;
  logic [ROW_IDX_W-1:0] row_cnt;
  logic [ROW_IDX_W-1:0] next_row_cnt;
  logic [WORD_W-1:0]    lower_word;
  logic [WORD_W-1:0]    row_addr;
  logic                 ram_done;
  logic                 row_done;

  // the RAM finishes one word per access cycle
  assign ram_done = (ram_state == ACCESS);

  // byte address of the lower word of the current row
  assign row_addr = sp_load_addr + (WORD_W'(row_cnt) * WORD_W'(ROW_STRIDE));

  // upper word of a row arrives
  assign row_done = (state == SP_LOAD2) && sp_load && ram_done;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state        <= IDLE;
      row_cnt      <= '0;
      sp_row_valid <= 1'b0;
      sp_row_idx   <= '0;
    end
    else begin
      state        <= next_state;
      row_cnt      <= next_row_cnt;
      sp_row_valid <= row_done;
      if (row_done) begin
        sp_row_idx <= row_cnt;
      end
    end
  end

  // row assembly, lower word held until the upper one shows up
  always_ff @(posedge CLK) begin
    if ((state == SP_LOAD1) && ram_done) begin
      lower_word <= ram_rdata;
    end
    if (row_done) begin
      sp_row_data <= {ram_rdata, lower_word};
    end
  end

  // grants only change in IDLE, fixed priority
  always_comb begin
    next_state   = state;
    next_row_cnt = row_cnt;
    case (state)
      IDLE: begin
        next_row_cnt = '0;
        if (sp_load) begin
          next_state = SP_LOAD1;
        end
        else if (sp_store) begin
          next_state = SP_STORE1;
        end
        else if (d_ren || d_wen) begin
          next_state = DCACHE;
        end
        else if (i_ren) begin
          next_state = ICACHE;
        end
      end
      SP_LOAD1: begin
        if (!sp_load) begin
          next_state = IDLE;
        end
        else if (ram_done) begin
          next_state = SP_LOAD2;
        end
      end
      SP_LOAD2: begin
        if (!sp_load) begin
          next_state = IDLE;
        end
        else if (ram_done) begin
          // last row ends the load
          if (row_cnt == ROW_IDX_W'(SP_ROWS - 1)) begin
            next_state = IDLE;
          end
          else begin
            next_state   = SP_LOAD1;
            next_row_cnt = row_cnt + 1'b1;
          end
        end
      end
      SP_STORE1: begin
        if (!sp_store) begin
          next_state = IDLE;
        end
        else if (ram_done) begin
          next_state = SP_STORE2;
        end
      end
      SP_STORE2: begin
        if (!sp_store || ram_done) begin
          next_state = IDLE;
        end
      end
      DCACHE: begin
        if (!(d_ren || d_wen) || ram_done) begin
          next_state = IDLE;
        end
      end
      ICACHE: begin
        if (!i_ren || ram_done) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  // steer the granted requester onto the RAM
  always_comb begin
    ram_addr  = '0;
    ram_wdata = '0;
    ram_ren   = 1'b0;
    ram_wen   = 1'b0;
    case (state)
      SP_LOAD1: begin
        ram_addr = row_addr;
        ram_ren  = 1'b1;
      end
      SP_LOAD2: begin
        ram_addr = row_addr + WORD_W'(HALF_OFFSET);
        ram_ren  = 1'b1;
      end
      SP_STORE1: begin
        ram_addr  = sp_store_addr;
        ram_wdata = sp_store_data[WORD_W-1:0];
        ram_wen   = 1'b1;
      end
      SP_STORE2: begin
        ram_addr  = sp_store_addr + WORD_W'(HALF_OFFSET);
        ram_wdata = sp_store_data[ROW_W-1:WORD_W];
        ram_wen   = 1'b1;
      end
      DCACHE: begin
        ram_addr  = d_addr;
        ram_wdata = d_wdata;
        ram_wen   = d_wen;
        // a write wins if both are raised
        ram_ren   = d_ren && !d_wen;
      end
      ICACHE: begin
        ram_addr = i_addr;
        ram_ren  = i_ren;
      end
      default: begin
      end
    endcase
  end

  // wait levels drop only in the granted access cycle
  assign d_wait = !((state == DCACHE) && ram_done);
  assign i_wait = !((state == ICACHE) && ram_done);

  assign d_rdata = ram_rdata;
  assign i_rdata = ram_rdata;

  assign sp_store_done = (state == SP_STORE2) && sp_store && ram_done;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys \
  -f files.f -o sim_tb &&
  ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

// File: scratchpad_buffer.sv
`default_nettype none

module scratchpad_buffer (
  input  logic                          CLK,
  input  logic                          nRST,
  // row stream from the arbiter
  input  logic                          row_valid,
  input  logic [arb_pkg::ROW_IDX_W-1:0] row_idx,
  input  logic [arb_pkg::ROW_W-1:0]     row_data,
  // read back port
  input  logic [arb_pkg::ROW_IDX_W-1:0] rd_idx,
  output logic [arb_pkg::ROW_W-1:0]     rd_row
);
  import arb_pkg::*;

  logic [ROW_W-1:0] rows [SP_ROWS];

  // each pulse overwrites one row slot
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int r = 0; r < SP_ROWS; r++) begin
        rows[r] <= '0;
      end
    end
    else if (row_valid) begin
      rows[row_idx] <= row_data;
    end
  end

  // combinational read
  assign rd_row = rows[rd_idx];

endmodule

`default_nettype wire

// File: tb_mem_subsys.sv
`default_nettype none

module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_pkg::*;
  import arb_pkg::*;

  localparam int TIMEOUT = 200;

  logic CLK, nRST, d_ren, d_wen, d_wait, i_ren, i_wait;
  logic sp_load, sp_store, sp_row_valid, sp_store_done;
  logic [WORD_W-1:0] d_addr, d_wdata, d_rdata, i_addr, i_rdata;
  logic [WORD_W-1:0] sp_load_addr, sp_store_addr;
  logic [ROW_W-1:0] sp_store_data, sp_row_data, sp_rd_row;
  logic [ROW_IDX_W-1:0] sp_row_idx, sp_rd_idx;

  // mirror of every word written so far
  logic [WORD_W-1:0] ref_mem [RAM_DEPTH];
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  mem_subsys_top UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  function automatic int widx(input logic [WORD_W-1:0] addr);
    return int'(addr[RAM_AW+1:2]);
  endfunction

  // row r is the lower word at base + r*stride and the upper word above it
  function automatic logic [ROW_W-1:0] row_expect(input logic [WORD_W-1:0] base, input int r);
    logic [WORD_W-1:0] lo;
    lo = base + WORD_W'(r * ROW_STRIDE);
    return {ref_mem[widx(lo + WORD_W'(HALF_OFFSET))], ref_mem[widx(lo)]};
  endfunction

  task automatic check_value(input string name, input logic [ROW_W-1:0] expected,
                             input logic [ROW_W-1:0] actual);
    assert (actual === expected)
    else begin
      $display("Fail %s expected %h actual %h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic note_problem(input string msg);
    $display("%s", msg);
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s: %0d error(s)", name, test_errors);
    test_errors = 0;
  endtask

  // single word access on the data or instruction cache port
  task automatic cache_access(input bit icache, input bit wr, input logic [WORD_W-1:0] addr,
                              input logic [WORD_W-1:0] data, output logic [WORD_W-1:0] rdata);
    int n;
    @(posedge CLK);
    if (icache) begin
      i_ren  <= 1'b1;
      i_addr <= addr;
    end
    else begin
      d_ren   <= !wr;
      d_wen   <= wr;
      d_addr  <= addr;
      d_wdata <= data;
    end
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while ((icache ? i_wait : d_wait) && n < TIMEOUT);
    if (icache ? i_wait : d_wait) begin
      note_problem("cache access never got its wait level dropped");
    end
    rdata = icache ? i_rdata : d_rdata;
    @(posedge CLK);
    i_ren <= 1'b0;
    d_ren <= 1'b0;
    d_wen <= 1'b0;
    if (wr) begin
      ref_mem[widx(addr)] = data;
    end
  endtask

  task automatic scratch_store(input logic [WORD_W-1:0] addr, input logic [ROW_W-1:0] data);
    int n;
    @(posedge CLK);
    sp_store      <= 1'b1;
    sp_store_addr <= addr;
    sp_store_data <= data;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (!sp_store_done && n < TIMEOUT);
    if (!sp_store_done) begin
      note_problem("scratchpad store never signalled done");
    end
    @(posedge CLK);
    sp_store <= 1'b0;
    ref_mem[widx(addr)] = data[WORD_W-1:0];
    ref_mem[widx(addr + WORD_W'(HALF_OFFSET))] = data[ROW_W-1:WORD_W];
  endtask

  // optionally raises a data cache read on the same edge as the load
  task automatic scratch_load(input logic [WORD_W-1:0] base, input bit with_dread,
                              input logic [WORD_W-1:0] daddr);
    int n;
    int rows;
    @(posedge CLK);
    sp_load      <= 1'b1;
    sp_load_addr <= base;
    if (with_dread) begin
      d_ren  <= 1'b1;
      d_addr <= daddr;
    end
    n = 0;
    rows = 0;
    do begin
      @(negedge CLK);
      n++;
      if (!d_wait) begin
        note_problem("data cache was served while the scratchpad load held the RAM");
      end
      if (sp_row_valid) begin
        check_value("row index", ROW_W'(rows), ROW_W'(sp_row_idx));
        check_value("row data", row_expect(base, rows), sp_row_data);
        rows++;
      end
    end while (!(sp_row_valid && sp_row_idx == ROW_IDX_W'(SP_ROWS - 1)) && n < TIMEOUT);
    if (rows != SP_ROWS) begin
      note_problem("scratchpad load did not deliver four rows in time");
    end
    @(posedge CLK);
    sp_load <= 1'b0;
  endtask

  initial begin
    logic [WORD_W-1:0] first_addr;
    logic [WORD_W-1:0] addr;
    logic [WORD_W-1:0] base;
    logic [WORD_W-1:0] rd;
    logic [ROW_W-1:0]  row;
    int unsigned       assert_fails;
    void'($urandom(32'hcf467980));
    nRST = 1'b0;
    {d_ren, d_wen, i_ren, sp_load, sp_store} = '0;
    {d_addr, d_wdata, i_addr, sp_load_addr, sp_store_addr} = '0;
    sp_store_data = '0;
    sp_rd_idx = '0;
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;

    @(negedge CLK);
    check_value("reset d_wait", ROW_W'(1), ROW_W'(d_wait));
    check_value("reset i_wait", ROW_W'(1), ROW_W'(i_wait));
    check_value("reset sp_row_valid", ROW_W'(0), ROW_W'(sp_row_valid));
    check_value("reset sp_store_done", ROW_W'(0), ROW_W'(sp_store_done));
    finish_test("reset_state");

    first_addr = WORD_W'(($urandom % 256) * 4);
    cache_access(0, 1, first_addr, $urandom, rd);
    cache_access(0, 0, first_addr, '0, rd);
    check_value("dcache readback", ROW_W'(ref_mem[widx(first_addr)]), ROW_W'(rd));
    finish_test("dcache_write_read");

    addr = WORD_W'(($urandom % 256) * 4);
    cache_access(0, 1, addr, $urandom, rd);
    cache_access(1, 0, addr, '0, rd);
    check_value("icache readback", ROW_W'(ref_mem[widx(addr)]), ROW_W'(rd));
    finish_test("icache_read");

    base = WORD_W'(1024 + ($urandom % 128) * 8);
    row = {$urandom, $urandom};
    scratch_store(base, row);
    cache_access(0, 0, base, '0, rd);
    check_value("store lower word", ROW_W'(row[WORD_W-1:0]), ROW_W'(rd));
    cache_access(0, 0, base + WORD_W'(HALF_OFFSET), '0, rd);
    check_value("store upper word", ROW_W'(row[ROW_W-1:WORD_W]), ROW_W'(rd));
    finish_test("scratchpad_store");

    base = WORD_W'(2048 + ($urandom % 64) * 8);
    for (int w = 0; w < 2 * SP_ROWS; w++) begin
      cache_access(0, 1, base + WORD_W'(w * 4), $urandom, rd);
    end
    scratch_load(base, 0, '0);
    for (int r = 0; r < SP_ROWS; r++) begin
      @(posedge CLK);
      sp_rd_idx <= ROW_IDX_W'(r);
      @(negedge CLK);
      check_value("buffer row", row_expect(base, r), sp_rd_row);
    end
    finish_test("scratchpad_load");

    // load and data cache read raised together, load has priority
    base = WORD_W'(3072 + ($urandom % 64) * 8);
    for (int w = 0; w < 2 * SP_ROWS; w++) begin
      cache_access(0, 1, base + WORD_W'(w * 4), $urandom, rd);
    end
    scratch_load(base, 1, first_addr);
    cache_access(0, 0, first_addr, '0, rd);
    check_value("dcache after load", ROW_W'(ref_mem[widx(first_addr)]), ROW_W'(rd));
    finish_test("load_priority");

    assert_fails = UUT.u_arbiter.u_checks.fail_cnt;
    $display("tests run %0d, tests failed %0d, assertion failures %0d",
             tests_run, tests_failed, assert_fails);
    if (tests_failed == 0 && assert_fails == 0) begin
      $display("TESTBENCH PASSED");
    end
    else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
